/* common/alu_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, opcodes and bus structs for the RV32 ALU
// Opcode bit 3 selects subtract or signed compare
// Opcode bit 2 selects a right rotation in the shifter
////////////////////////////////////////////////////////////

package alu_pkg;

  // Data word width, fixed by RV32
  localparam int XLEN    = 32;
  // Shift amount field of operand b
  localparam int SHAMT_W = 5;
  // Counts run from 0 to 32 inclusive
  localparam int COUNT_W = 6;

  // Layout {unit[1:0], variant, right_shift, sub_op[1:0]}
  // Unit 00 add and logic, 01 shifter, 10 compare, 11 unary
  typedef enum logic [5:0] {
    ALU_ADD    = 6'b00_0000,
    ALU_AND    = 6'b00_0001,
    ALU_OR     = 6'b00_0010,
    ALU_XOR    = 6'b00_0011,
    ALU_ANDN   = 6'b00_0101,
    ALU_ORN    = 6'b00_0110,
    ALU_XNOR   = 6'b00_0111,
    ALU_SUB    = 6'b00_1000,
    // Shifter group, bit 2 marks right rotation
    ALU_SLL    = 6'b01_0000,
    ALU_ROL    = 6'b01_0001,
    ALU_SRL    = 6'b01_0100,
    ALU_SRA    = 6'b01_0101,
    ALU_ROR    = 6'b01_0110,
    ALU_BSET   = 6'b01_1000,
    ALU_BCLR   = 6'b01_1001,
    ALU_BINV   = 6'b01_1010,
    // bext moves the addressed bit down to bit 0
    ALU_BEXT   = 6'b01_1100,
    // Compare group, bit 3 marks the signed form
    ALU_EQ     = 6'b10_0000,
    ALU_NE     = 6'b10_0001,
    ALU_LTU    = 6'b10_0010,
    ALU_GEU    = 6'b10_0011,
    ALU_SLTU   = 6'b10_0100,
    ALU_MINU   = 6'b10_0101,
    ALU_MAXU   = 6'b10_0110,
    ALU_LT     = 6'b10_1010,
    ALU_GE     = 6'b10_1011,
    ALU_SLT    = 6'b10_1100,
    ALU_MIN    = 6'b10_1101,
    ALU_MAX    = 6'b10_1110,
    // Unary ops on operand a only
    ALU_CLZ    = 6'b11_0000,
    ALU_CTZ    = 6'b11_0001,
    ALU_CPOP   = 6'b11_0010,
    ALU_ORC_B  = 6'b11_0011,
    ALU_REV8   = 6'b11_0100,
    ALU_SEXT_B = 6'b11_0101,
    ALU_SEXT_H = 6'b11_0110,
    ALU_ZEXT_H = 6'b11_0111
  } alu_opcode_e;

  // Field view of the same six bits
  typedef struct packed {
    logic [1:0] unit;
    logic       variant;
    logic       right_shift;
    logic [1:0] sub_op;
  } alu_op_fields_t;

  typedef union packed {
    alu_opcode_e    opcode;
    alu_op_fields_t fields;
  } alu_op_u;

  typedef struct packed {
    alu_op_u         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            cmp_result;
    logic            fault;
  } alu_rsp_t;

endpackage

/* hw/alu/alu_adder.sv */
////////////////////////////////////////////////////////////
// Duplicated add/subtract, purely combinational
// fault_o flags any mismatch between the two copies
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_adder (
  input  alu_pkg::alu_op_u         op_i,
  input  logic [alu_pkg::XLEN-1:0] operand_a_i,
  input  logic [alu_pkg::XLEN-1:0] operand_b_i,
  output logic [alu_pkg::XLEN-1:0] result_o,
  output logic                     fault_o
);
  import alu_pkg::*;

  // Primary copy
  logic            subtract_p;
  logic [XLEN:0]   in_b_p;
  logic [XLEN+1:0] sum_p;
  // Redundant copy
  logic            subtract_r;
  logic [XLEN:0]   in_b_r;
  logic [XLEN+1:0] sum_r;

  // Variant bit turns add into subtract
  assign subtract_p = op_i.fields.variant;
  assign subtract_r = op_i.fields.variant;

  // Carry-in rides in bit 0, a's extra 1 propagates it
  assign in_b_p = {subtract_p ? ~operand_b_i : operand_b_i, subtract_p};
  assign sum_p  = {1'b0, operand_a_i, 1'b1} + {1'b0, in_b_p};

  assign in_b_r = {subtract_r ? ~operand_b_i : operand_b_i, subtract_r};
  assign sum_r  = {1'b0, operand_a_i, 1'b1} + {1'b0, in_b_r};

  // Drop carry-in slot and carry-out
  assign result_o = sum_p[XLEN:1];

  // Copies must always agree
  assign fault_o = (sum_p[XLEN:1] != sum_r[XLEN:1]);

endmodule

/* hw/alu/alu_bitcount.sv */
////////////////////////////////////////////////////////////
// Leading/trailing zero count and population count
// Zero input counts as 32 for both clz and ctz
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_bitcount (
  input  alu_pkg::alu_op_u            op_i,
  input  logic [alu_pkg::XLEN-1:0]    operand_a_i,
  output logic [alu_pkg::COUNT_W-1:0] count_o
);
  import alu_pkg::*;

  logic [XLEN-1:0]    a_rev;
  // Word scanned from bit 0 upward
  logic [XLEN-1:0]    scan;
  // Index of the lowest set bit
  logic [SHAMT_W-1:0] first_one;
  logic               no_ones;
  logic [COUNT_W-1:0] zero_count;
  logic [COUNT_W-1:0] pop_count;

  // clz is ctz of the bit-reversed word
  assign a_rev = {<<{operand_a_i}};
  assign scan  = (op_i.opcode == ALU_CTZ) ? operand_a_i : a_rev;

  // Find first one, lowest index wins
  always_comb begin
    first_one = '0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (scan[i]) begin
        first_one = SHAMT_W'(i);
      end
    end
  end

  assign no_ones    = ~|scan;
  assign zero_count = no_ones ? COUNT_W'(XLEN) : {1'b0, first_one};

  ////////////////////////////////////////////////////////////
  // Population count
  ////////////////////////////////////////////////////////////

  // Plain adder chain, short enough for one cycle at 32 bits
  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + COUNT_W'(operand_a_i[i]);
    end
  end

  // clz and ctz share the scan path
  assign count_o = (op_i.opcode == ALU_CPOP) ? pop_count : zero_count;

endmodule

/* hw/alu/alu_compare.sv */
////////////////////////////////////////////////////////////
// Equal/greater comparator for branches, slt and min/max
// Signed when opcode bit 3 is set, unsigned otherwise
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_compare (
  input  alu_pkg::alu_op_u         op_i,
  input  logic [alu_pkg::XLEN-1:0] operand_a_i,
  input  logic [alu_pkg::XLEN-1:0] operand_b_i,
  output logic                     cmp_result_o,
  output logic                     less_o,
  output logic [alu_pkg::XLEN-1:0] min_o,
  output logic [alu_pkg::XLEN-1:0] max_o
);
  import alu_pkg::*;

  logic is_signed;
  logic is_equal;
  // Single compare covers both signed and unsigned
  logic is_greater;

  assign is_signed = op_i.fields.variant;
  assign is_equal  = (operand_a_i == operand_b_i);

  // Extend by one bit, sign only for the signed forms
  assign is_greater = $signed({operand_a_i[XLEN-1] & is_signed, operand_a_i}) >
                      $signed({operand_b_i[XLEN-1] & is_signed, operand_b_i});

  // Less-than is neither greater nor equal
  assign less_o = ~(is_greater | is_equal);

  // Branch decision
  always_comb begin
    cmp_result_o = is_equal;
    case (op_i.opcode)
      ALU_EQ:          cmp_result_o = is_equal;
      ALU_NE:          cmp_result_o = ~is_equal;
      ALU_GE, ALU_GEU: cmp_result_o = is_greater | is_equal;
      ALU_LT, ALU_LTU: cmp_result_o = less_o;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Min and max
  ////////////////////////////////////////////////////////////

  // Equal operands make the choice irrelevant
  assign min_o = is_greater ? operand_b_i : operand_a_i;
  assign max_o = is_greater ? operand_a_i : operand_b_i;

endmodule

/* hw/alu/alu_shifter.sv */
////////////////////////////////////////////////////////////
// 64-bit left rotator serving shifts, rotates and Zbs ops
// Right shifts rotate by the negated amount
// A second rotation must bring the pair back, else fault
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_shifter (
  input  alu_pkg::alu_op_u         op_i,
  input  logic [alu_pkg::XLEN-1:0] operand_a_i,
  input  logic [alu_pkg::XLEN-1:0] operand_b_i,
  output logic [alu_pkg::XLEN-1:0] result_o,
  output logic                     fault_o
);
  import alu_pkg::*;

  // Amount modulo 64, one bit wider than a 32-bit shamt
  logic [SHAMT_W:0]   shamt;
  logic [SHAMT_W:0]   back_amt;
  // Upper word fills in, lower word is shifted
  logic [XLEN-1:0]    fill_hi;
  logic [XLEN-1:0]    data_lo;
  logic [2*XLEN-1:0]  pair;
  logic [2*XLEN-1:0]  rotated;
  logic [2*XLEN-1:0]  restored;

  // Log-depth rotate left, one stage per amount bit
  function automatic logic [2*XLEN-1:0] rotl(
    input logic [2*XLEN-1:0] word,
    input logic [SHAMT_W:0]  amt
  );
    logic [2*XLEN-1:0] tmp;
    int unsigned       step;
    tmp = word;
    for (int i = SHAMT_W; i >= 0; i--) begin
      step = 1 << i;
      if (amt[i]) begin
        tmp = (tmp << step) | (tmp >> (2 * XLEN - step));
      end
    end
    return tmp;
  endfunction

  // Rotating left by 64-n equals rotating right by n
  always_comb begin
    if (op_i.fields.right_shift) begin
      shamt = -{1'b0, operand_b_i[SHAMT_W-1:0]};
    end else begin
      shamt = {1'b0, operand_b_i[SHAMT_W-1:0]};
    end
  end

  // Fill word and data word per operation
  always_comb begin
    fill_hi = '0;
    data_lo = operand_a_i;
    case (op_i.opcode)
      // Sign bits enter from above on sra
      ALU_SRA: fill_hi = {XLEN{operand_a_i[XLEN-1]}};
      // Rotates wrap the operand around itself
      ALU_ROL,
      ALU_ROR: fill_hi = operand_a_i;
      // Single-bit ops move a lone one into place
      ALU_BSET,
      ALU_BCLR,
      ALU_BINV: data_lo = {{(XLEN-1){1'b0}}, 1'b1};
      default: ;
    endcase
  end

  assign pair    = {fill_hi, data_lo};
  assign rotated = rotl(pair, shamt);

  // Combine the rotated word with operand a for Zbs
  always_comb begin
    result_o = rotated[XLEN-1:0];
    case (op_i.opcode)
      ALU_BEXT: result_o = {{(XLEN-1){1'b0}}, rotated[0]};
      ALU_BSET: result_o = operand_a_i | rotated[XLEN-1:0];
      ALU_BCLR: result_o = operand_a_i & ~rotated[XLEN-1:0];
      ALU_BINV: result_o = operand_a_i ^ rotated[XLEN-1:0];
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Self-check
  ////////////////////////////////////////////////////////////

  // Two's complement amount completes a full turn of 64
  assign back_amt = -shamt;
  assign restored = rotl(rotated, back_amt);

  // Both halves must match the starting pair
  assign fault_o = (restored != pair);

endmodule

/* hw/alu_result_stage.sv */
////////////////////////////////////////////////////////////
// Result select and output register, one cycle latency
// rsp_o holds until the next accepted request
// Unknown opcodes return a zero result
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_result_stage (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        req_valid_i,
  input  alu_pkg::alu_req_t           req_i,
  input  logic [alu_pkg::XLEN-1:0]    adder_result_i,
  input  logic [alu_pkg::XLEN-1:0]    shift_result_i,
  input  logic [alu_pkg::XLEN-1:0]    min_i,
  input  logic [alu_pkg::XLEN-1:0]    max_i,
  input  logic                        less_i,
  input  logic                        cmp_result_i,
  input  logic                        adder_fault_i,
  input  logic                        shift_fault_i,
  input  logic [alu_pkg::COUNT_W-1:0] count_i,
  output logic                        rsp_valid_o,
  output alu_pkg::alu_rsp_t           rsp_o
);
  import alu_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  // Byte-wise results
  logic [XLEN-1:0] orc_b;
  logic [XLEN-1:0] rev8;
  logic [XLEN-1:0] result;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  // orc.b smears each byte, rev8 swaps byte order
  always_comb begin
    for (int b = 0; b < XLEN / 8; b++) begin
      orc_b[8*b +: 8] = {8{|op_a[8*b +: 8]}};
      rev8[8*b +: 8]  = op_a[8*(XLEN/8-1-b) +: 8];
    end
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    result = '0;
    case (req_i.op.opcode)
      // Logic ops computed here
      ALU_AND:              result = op_a & op_b;
      ALU_OR:               result = op_a | op_b;
      ALU_XOR:              result = op_a ^ op_b;
      ALU_ANDN:             result = op_a & ~op_b;
      ALU_ORN:              result = op_a | ~op_b;
      ALU_XNOR:             result = op_a ^ ~op_b;
      ALU_ADD, ALU_SUB:     result = adder_result_i;
      ALU_SLL, ALU_SRL,
      ALU_SRA, ALU_ROL,
      ALU_ROR, ALU_BSET,
      ALU_BCLR, ALU_BINV,
      ALU_BEXT:             result = shift_result_i;
      ALU_SLT, ALU_SLTU:    result = {{(XLEN-1){1'b0}}, less_i};
      ALU_MIN, ALU_MINU:    result = min_i;
      ALU_MAX, ALU_MAXU:    result = max_i;
      ALU_CLZ, ALU_CTZ,
      ALU_CPOP:             result = {{(XLEN-COUNT_W){1'b0}}, count_i};
      ALU_ORC_B:            result = orc_b;
      ALU_REV8:             result = rev8;
      // Sign and zero extension of the low byte or half
      ALU_SEXT_B:           result = {{(XLEN-8){op_a[7]}}, op_a[7:0]};
      ALU_SEXT_H:           result = {{(XLEN-16){op_a[15]}}, op_a[15:0]};
      ALU_ZEXT_H:           result = {{(XLEN-16){1'b0}}, op_a[15:0]};
      default: ;
    endcase
  end

  // Valid follows the strobe, payload only loads on a request
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_valid_i;
      if (req_valid_i) begin
        rsp_o.result     <= result;
        rsp_o.cmp_result <= cmp_result_i;
        rsp_o.fault      <= adder_fault_i | shift_fault_i;
      end
    end
  end

endmodule

/* hw/alu_top.sv */
////////////////////////////////////////////////////////////
// Registered RV32I + Zbb subset + Zbs ALU
// Response one cycle after each strobe, no back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_top (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              req_valid_i,
  input  alu_pkg::alu_req_t req_i,
  output logic              rsp_valid_o,
  output alu_pkg::alu_rsp_t rsp_o
);
  import alu_pkg::*;

  // Adder outputs
  logic [XLEN-1:0]    adder_result;
  logic               adder_fault;
  // Shifter outputs
  logic [XLEN-1:0]    shift_result;
  logic               shift_fault;
  // Comparator outputs
  logic               is_less;
  logic               cmp_result;
  logic [XLEN-1:0]    min_result;
  logic [XLEN-1:0]    max_result;
  // Counter output
  logic [COUNT_W-1:0] count_result;

  alu_adder u_adder (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .result_o    (adder_result),
    .fault_o     (adder_fault)
  );

  alu_shifter u_shifter (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .result_o    (shift_result),
    .fault_o     (shift_fault)
  );

  alu_compare u_compare (
    .op_i         (req_i.op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .cmp_result_o (cmp_result),
    .less_o       (is_less),
    .min_o        (min_result),
    .max_o        (max_result)
  );

  // Only operand a is counted
  alu_bitcount u_bitcount (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .count_o     (count_result)
  );

  alu_result_stage u_result_stage (
    .clk            (clk),
    .reset_i        (reset_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .adder_result_i (adder_result),
    .shift_result_i (shift_result),
    .min_i          (min_result),
    .max_i          (max_result),
    .less_i         (is_less),
    .cmp_result_i   (cmp_result),
    .adder_fault_i  (adder_fault),
    .shift_fault_i  (shift_fault),
    .count_i        (count_result),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_alu -o tb_alu

./obj_dir/tb_alu > "$LOG" 2>&1 || true
cat "$LOG"

# The log decides the outcome
if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

/* sim/tb_alu.sv */
////////////////////////////////////////////////////////////
// Directed testbench for alu_top, one response per strobe
// Inputs change 1 ns after the rising edge, outputs checked
// 1 ns after the edge that registers them
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_alu;
  import alu_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CORNER   = 6;
  localparam int NUM_RAND     = 8;
  localparam int MIX_OPS      = 10;
  // Request counts per test size the watchdog
  localparam int REQS_ARITH = 8 * (NUM_CORNER * NUM_CORNER + NUM_RAND);
  localparam int REQS_SHIFT = 9 * 32;
  localparam int REQS_CMP   = 12 * (NUM_CORNER * NUM_CORNER + NUM_RAND);
  localparam int REQS_COUNT = 8 * (NUM_CORNER + NUM_RAND);
  localparam int REQS_B2B   = 40;
  localparam int REQS_TOTAL = 1 + REQS_ARITH + REQS_SHIFT + REQS_CMP + REQS_COUNT + REQS_B2B;
  // Idle cycles and slack on top of one cycle per request
  localparam int WATCHDOG_NS = (REQS_TOTAL + RESET_CYCLES + 100) * CLK_PERIOD;

  logic     clk;
  logic     reset_i;
  logic     req_valid;
  alu_req_t req;
  logic     rsp_valid_o;
  alu_rsp_t rsp_o;

  integer seed;
  int     num_errors;
  int     num_checks;
  int     num_reqs;
  int     num_tests;
  string  cur_op;

  // Sign boundaries, all ones and the low half mask
  logic [XLEN-1:0] corner_vals [NUM_CORNER] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                                32'h8000_0000, 32'h7fff_ffff, 32'h0000_ffff};
  alu_opcode_e arith_ops [8] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_ANDN,
                                 ALU_ORN, ALU_XNOR};
  alu_opcode_e shift_ops [9] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROL, ALU_ROR, ALU_BSET,
                                 ALU_BCLR, ALU_BINV, ALU_BEXT};
  alu_opcode_e cmp_ops [12] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_SLT,
                                ALU_SLTU, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU};
  alu_opcode_e unary_ops [8] = '{ALU_CLZ, ALU_CTZ, ALU_CPOP, ALU_ORC_B, ALU_REV8,
                                 ALU_SEXT_B, ALU_SEXT_H, ALU_ZEXT_H};
  alu_opcode_e mix_ops [MIX_OPS] = '{ALU_ADD, ALU_SUB, ALU_SRA, ALU_ROR, ALU_BINV, ALU_SLT,
                                     ALU_MAXU, ALU_GE, ALU_CLZ, ALU_REV8};

  alu_top UUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Expected result word from the ISA definition of each op
  function automatic logic [XLEN-1:0] ref_result(input alu_opcode_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    int              sh;
    int              cnt;
    sh  = int'(b[SHAMT_W-1:0]);
    r   = '0;
    cnt = XLEN;
    case (op)
      ALU_ADD:    r = a + b;
      ALU_SUB:    r = a - b;
      ALU_AND:    r = a & b;
      ALU_OR:     r = a | b;
      ALU_XOR:    r = a ^ b;
      ALU_ANDN:   r = a & ~b;
      ALU_ORN:    r = a | ~b;
      ALU_XNOR:   r = ~(a ^ b);
      ALU_SLL:    r = a << sh;
      ALU_SRL:    r = a >> sh;
      ALU_SRA:    r = $signed(a) >>> sh;
      // A shift by 32 gives zero, so amount 0 needs no special case
      ALU_ROL:    r = (a << sh) | (a >> (XLEN - sh));
      ALU_ROR:    r = (a >> sh) | (a << (XLEN - sh));
      ALU_BSET:   r = a | (32'h1 << sh);
      ALU_BCLR:   r = a & ~(32'h1 << sh);
      ALU_BINV:   r = a ^ (32'h1 << sh);
      ALU_BEXT:   r = (a >> sh) & 32'h1;
      ALU_SLT:    r = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   r = {31'b0, a < b};
      ALU_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      ALU_MINU:   r = (a < b) ? a : b;
      ALU_MAX:    r = ($signed(a) > $signed(b)) ? a : b;
      ALU_MAXU:   r = (a > b) ? a : b;
      ALU_CLZ: begin
        // Highest set bit wins as the last one seen
        for (int i = 0; i < XLEN; i++) begin
          if (a[i]) cnt = XLEN - 1 - i;
        end
        r = XLEN'(cnt);
      end
      ALU_CTZ: begin
        for (int i = XLEN - 1; i >= 0; i--) begin
          if (a[i]) cnt = i;
        end
        r = XLEN'(cnt);
      end
      ALU_CPOP:   r = XLEN'($countones(a));
      ALU_ORC_B: begin
        for (int i = 0; i < 4; i++) begin
          r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      ALU_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      ALU_SEXT_B: r = {{24{a[7]}}, a[7:0]};
      ALU_SEXT_H: r = {{16{a[15]}}, a[15:0]};
      ALU_ZEXT_H: r = {16'h0000, a[15:0]};
      default:    r = '0;
    endcase
    return r;
  endfunction

  // Branch bit where non-branch ops report operand equality
  function automatic logic ref_cmp(input alu_opcode_e op,
                                   input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
    case (op)
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_LTU: return a < b;
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_GEU: return a >= b;
      default: return a == b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    num_checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s (%s) expected %h, got %h",
               $time, name, cur_op, exp, got);
      num_errors++;
    end
  endtask

  // Strobe one request, then check its response one edge later
  task automatic send_req(input alu_opcode_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp_res;
    logic            exp_cmp;
    exp_res       = ref_result(op, a, b);
    exp_cmp       = ref_cmp(op, a, b);
    req_valid     = 1'b1;
    req.op.opcode = op;
    req.operand_a = a;
    req.operand_b = b;
    @(posedge clk);
    #1;
    num_reqs++;
    cur_op = op.name();
    check_value("rsp_valid_o", 1'b1, rsp_valid_o);
    check_value("rsp_o.result", exp_res, rsp_o.result);
    check_value("rsp_o.cmp_result", exp_cmp, rsp_o.cmp_result);
    check_value("rsp_o.fault", 1'b0, rsp_o.fault);
  endtask

  // No strobe for one cycle, so no response may appear
  task automatic idle_cycle();
    req_valid = 1'b0;
    @(posedge clk);
    #1;
    cur_op = "idle";
    check_value("rsp_valid_o", 1'b0, rsp_valid_o);
  endtask

  task automatic report_test(input string name, input int start_errors);
    num_tests++;
    if (num_errors == start_errors) begin
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      $display("[%0t ns] %s: %0d errors", $time, name, num_errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_latency();
    int start_errors;
    start_errors = num_errors;
    cur_op = "after reset";
    check_value("rsp_valid_o", 1'b0, rsp_valid_o);
    check_value("rsp_o.result", '0, rsp_o.result);
    check_value("rsp_o.cmp_result", 1'b0, rsp_o.cmp_result);
    check_value("rsp_o.fault", 1'b0, rsp_o.fault);
    send_req(ALU_ADD, 32'h1234_5678, 32'h1111_1111);
    // Register still holds the response after strobe and payload drop
    req_valid = 1'b0;
    req       = '0;
    #1;
    cur_op = "before edge";
    check_value("rsp_valid_o", 1'b1, rsp_valid_o);
    check_value("rsp_o.result", 32'h2345_6789, rsp_o.result);
    @(posedge clk);
    #1;
    cur_op = "idle";
    check_value("rsp_valid_o", 1'b0, rsp_valid_o);
    idle_cycle();
    // Payload holds with no new request
    cur_op = "hold";
    check_value("rsp_o.result", 32'h2345_6789, rsp_o.result);
    report_test("reset_latency", start_errors);
  endtask

  // Sweeps every corner pair, then random pairs, per op in the list
  task automatic sweep_pairs(input int which);
    alu_opcode_e op;
    int          n_ops;
    n_ops = (which == 0) ? 8 : 12;
    for (int k = 0; k < n_ops; k++) begin
      op = (which == 0) ? arith_ops[k] : cmp_ops[k];
      for (int i = 0; i < NUM_CORNER; i++) begin
        for (int j = 0; j < NUM_CORNER; j++) begin
          send_req(op, corner_vals[i], corner_vals[j]);
        end
      end
      for (int r = 0; r < NUM_RAND; r++) begin
        send_req(op, $random(seed), $random(seed));
      end
    end
    idle_cycle();
  endtask

  task automatic test_arith_logic();
    int start_errors;
    start_errors = num_errors;
    sweep_pairs(0);
    report_test("arith_logic", start_errors);
  endtask

  task automatic test_shift_bitops();
    int              start_errors;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    start_errors = num_errors;
    for (int k = 0; k < 9; k++) begin
      for (int amt = 0; amt < 32; amt++) begin
        a = $random(seed);
        // Odd amounts force a negative operand for sra
        if (amt % 2 == 1) a[XLEN-1] = 1'b1;
        // Upper bits of b are noise and must be ignored
        b = $random(seed);
        b[SHAMT_W-1:0] = SHAMT_W'(amt);
        send_req(shift_ops[k], a, b);
      end
    end
    idle_cycle();
    report_test("shift_bitops", start_errors);
  endtask

  task automatic test_compares();
    int start_errors;
    start_errors = num_errors;
    sweep_pairs(1);
    report_test("compares", start_errors);
  endtask

  task automatic test_counts_bytes();
    int start_errors;
    start_errors = num_errors;
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < NUM_CORNER; i++) begin
        send_req(unary_ops[k], corner_vals[i], $random(seed));
      end
      for (int r = 0; r < NUM_RAND; r++) begin
        send_req(unary_ops[k], $random(seed), $random(seed));
      end
    end
    idle_cycle();
    report_test("counts_bytes", start_errors);
  endtask

  task automatic test_back_to_back();
    int start_errors;
    int idx;
    start_errors = num_errors;
    for (int r = 0; r < REQS_B2B; r++) begin
      idx = int'($unsigned($random(seed)) % MIX_OPS);
      send_req(mix_ops[idx], $random(seed), $random(seed));
    end
    idle_cycle();
    report_test("back_to_back", start_errors);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed       = 32'hf601b630;
    num_errors = 0;
    num_checks = 0;
    num_reqs   = 0;
    num_tests  = 0;
    cur_op     = "none";
    reset_i    = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_i = 1'b0;
    test_reset_latency();
    test_arith_logic();
    test_shift_bitops();
    test_compares();
    test_counts_bytes();
    test_back_to_back();
    $display("Summary: %0d tests, %0d requests, %0d checks, %0d errors",
             num_tests, num_reqs, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/alu_pkg.sv
hw/alu/alu_adder.sv
hw/alu/alu_shifter.sv
hw/alu/alu_compare.sv
hw/alu/alu_bitcount.sv
hw/alu_result_stage.sv
hw/alu_top.sv
sim/tb_alu.sv
